// File: rtl/imuldiv_types_pkg.sv
// imuldiv data types
// operand, result and function code widths shared by the datapaths and the top

package imuldiv_types_pkg;

  // ------------------------------------------------------------------------
  // operand and result words
  // ------------------------------------------------------------------------

  // one signed 32-bit register word, as seen on the request side
  typedef logic signed [31:0] operand_t;

  // two words on the response side
  // mul: full 64-bit product
  // div: remainder in [63:32], quotient in [31:0]
  typedef logic [63:0] result_t;

  // ------------------------------------------------------------------------
  // request and response tagging
  // ------------------------------------------------------------------------

  // selects multiply or divide, also tags each response
  typedef logic fn_t;

endpackage

// File: rtl/imuldiv_ctrl_pkg.sv
// imuldiv control definitions
// function codes, unit FSM states and the iteration counter used by both units

package imuldiv_ctrl_pkg;

  // ------------------------------------------------------------------------
  // function codes
  // ------------------------------------------------------------------------

  localparam imuldiv_types_pkg::fn_t FN_MUL = 1'b0;
  localparam imuldiv_types_pkg::fn_t FN_DIV = 1'b1;

  // ------------------------------------------------------------------------
  // iterative unit FSM
  // ------------------------------------------------------------------------

  // idle: waiting for a request, calc: one bit per cycle, done: holding result
  typedef enum logic [1:0] {IDLE, CALC, DONE} unit_state_t;

  // wide enough for 0..31 with headroom
  typedef logic [5:0] count_t;

  // final count value spent in calc, gives 32 steps in total
  localparam count_t LAST_ITER = 6'd31;

endpackage

// File: rtl/imuldiv_req_if.sv
// imuldiv request channel
// operand pair with val/rdy handshake from the dispatcher to one iterative unit

`timescale 1ns/1ps

interface imuldiv_req_if;

  // operands go to both units, only the selected val rises
  imuldiv_types_pkg::operand_t a;
  imuldiv_types_pkg::operand_t b;
  logic                        val;
  // unit side: high in idle only
  logic                        rdy;

  // dispatcher drives the request
  modport dispatch (output a, output b, output val, input rdy);

  // unit accepts it
  modport unit (input a, input b, input val, output rdy);

endinterface

// File: rtl/imuldiv_req_dispatch.sv
// imuldiv request dispatcher
// steers one request to the multiplier or divider by function code

`timescale 1ns/1ps

module imuldiv_req_dispatch (
  input  imuldiv_types_pkg::fn_t      req_fn,
  input  imuldiv_types_pkg::operand_t req_a,
  input  imuldiv_types_pkg::operand_t req_b,
  input  logic                        req_val,
  output logic                        req_rdy,
  imuldiv_req_if.dispatch             mul_req,
  imuldiv_req_if.dispatch             div_req
);

  logic sel_div;

  // one-bit decode of the function code
  assign sel_div = (req_fn == imuldiv_ctrl_pkg::FN_DIV);

  // operands fan out to both units
  assign mul_req.a = req_a;
  assign mul_req.b = req_b;
  assign div_req.a = req_a;
  assign div_req.b = req_b;

  // only the addressed unit sees a valid request
  assign mul_req.val = req_val && !sel_div;
  assign div_req.val = req_val && sel_div;

  // requester waits on the addressed unit only
  // so a busy divider never blocks a multiply and vice versa
  assign req_rdy = sel_div ? div_req.rdy : mul_req.rdy;

endmodule

// File: rtl/imuldiv_int_mul_iterative.sv
// iterative signed multiplier
// shift-and-add datapath under a three-state control FSM, 32 steps per product

`timescale 1ns/1ps

module imuldiv_int_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,
  imuldiv_req_if.unit                req,
  output imuldiv_types_pkg::result_t resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;

  // registers, shifter and accumulator
  imuldiv_int_mul_dpath i_dpath (
    .clk       (clk),
    .reset     (reset),
    .req_a     (req.a),
    .req_b     (req.b),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel),
    .result    (resp_result)
  );

  // picks load or shift for each register every cycle
  imuldiv_int_mul_ctrl i_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req.val),
    .req_rdy   (req.rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel)
  );

endmodule

// ------------------------------------------------------------------------
// datapath
// ------------------------------------------------------------------------

module imuldiv_int_mul_dpath (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_types_pkg::operand_t req_a,
  input  imuldiv_types_pkg::operand_t req_b,
  input  logic                        a_en,
  input  logic                        a_mux_sel,
  input  logic                        b_en,
  input  logic                        b_mux_sel,
  output imuldiv_types_pkg::result_t  result
);

  logic        sign_a_reg;
  logic        sign_b_reg;
  logic [63:0] a_reg;
  logic [31:0] b_reg;
  logic [63:0] acc_reg;
  logic [31:0] mag_a;
  logic [31:0] mag_b;
  logic [63:0] a_next;
  logic [31:0] b_next;

  // magnitudes, most negative value maps to 0x80000000 which is still right
  assign mag_a = req_a[31] ? (~req_a + 32'd1) : req_a;
  assign mag_b = req_b[31] ? (~req_b + 32'd1) : req_b;

  // mux select 0 loads fresh operands, 1 takes the shifted value
  assign a_next = a_mux_sel ? {a_reg[62:0], 1'b0} : {32'd0, mag_a};
  assign b_next = b_mux_sel ? {1'b0, b_reg[31:1]} : mag_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (a_en && !a_mux_sel) begin
      sign_a_reg <= req_a[31];
      sign_b_reg <= req_b[31];
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_next;
    end
    // clear on load, then add the shifted a wherever b has a one
    if (a_en && !a_mux_sel) begin
      acc_reg <= 64'd0;
    end else if (a_en && b_reg[0]) begin
      acc_reg <= acc_reg + a_reg;
    end
  end

  // negate when exactly one operand was negative
  assign result = (sign_a_reg ^ sign_b_reg) ? (~acc_reg + 64'd1) : acc_reg;

endmodule

// ------------------------------------------------------------------------
// control
// ------------------------------------------------------------------------

module imuldiv_int_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel
);

  imuldiv_ctrl_pkg::unit_state_t state;
  imuldiv_ctrl_pkg::count_t      count;
  logic                          req_go;

  assign req_go = req_val && req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_ctrl_pkg::IDLE;
      count <= '0;
    end else begin
      case (state)
        imuldiv_ctrl_pkg::IDLE: begin
          if (req_go) begin
            state <= imuldiv_ctrl_pkg::CALC;
            count <= '0;
          end
        end
        imuldiv_ctrl_pkg::CALC: begin
          // step 31 is the last one
          if (count == imuldiv_ctrl_pkg::LAST_ITER) begin
            state <= imuldiv_ctrl_pkg::DONE;
          end else begin
            count <= count + 6'd1;
          end
        end
        default: begin
          // hold the product until the arbiter takes it
          if (resp_val && resp_rdy) begin
            state <= imuldiv_ctrl_pkg::IDLE;
          end
        end
      endcase
    end
  end

  // outputs decoded from state only, plus the load strobe in idle
  always_comb begin
    req_rdy   = (state == imuldiv_ctrl_pkg::IDLE);
    resp_val  = (state == imuldiv_ctrl_pkg::DONE);
    a_mux_sel = (state == imuldiv_ctrl_pkg::CALC);
    b_mux_sel = (state == imuldiv_ctrl_pkg::CALC);
    a_en      = a_mux_sel || req_go;
    b_en      = b_mux_sel || req_go;
  end

endmodule

// File: rtl/imuldiv_int_div_iterative.sv
// iterative signed divider
// restoring shift-and-subtract datapath, one quotient bit per cycle for 32 cycles

`timescale 1ns/1ps

module imuldiv_int_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  imuldiv_req_if.unit                req,
  output imuldiv_types_pkg::result_t resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  logic load_en;
  logic step_en;

  imuldiv_int_div_dpath i_dpath (
    .clk     (clk),
    .reset   (reset),
    .req_a   (req.a),
    .req_b   (req.b),
    .load_en (load_en),
    .step_en (step_en),
    .result  (resp_result)
  );

  imuldiv_int_div_ctrl i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req.val),
    .req_rdy  (req.rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load_en  (load_en),
    .step_en  (step_en)
  );

endmodule

// ------------------------------------------------------------------------
// datapath
// ------------------------------------------------------------------------

module imuldiv_int_div_dpath (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_types_pkg::operand_t req_a,
  input  imuldiv_types_pkg::operand_t req_b,
  input  logic                        load_en,
  input  logic                        step_en,
  output imuldiv_types_pkg::result_t  result
);

  logic        sign_q_reg;
  logic        sign_r_reg;
  // remainder in the upper half, dividend bits shift into it from below
  logic [63:0] pair_reg;
  logic [31:0] divisor_reg;
  logic [31:0] mag_a;
  logic [31:0] mag_b;
  logic [63:0] shifted;
  logic [32:0] diff;
  logic [31:0] quo_mag;
  logic [31:0] rem_mag;
  logic        div_zero;

  assign mag_a = req_a[31] ? (~req_a + 32'd1) : req_a;
  assign mag_b = req_b[31] ? (~req_b + 32'd1) : req_b;

  // remainder stays below the divisor, so bit 63 is always zero before the shift
  assign shifted = {pair_reg[62:0], 1'b0};
  // extra bit catches the borrow
  assign diff    = {1'b0, shifted[63:32]} - {1'b0, divisor_reg};

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_q_reg <= 1'b0;
      sign_r_reg <= 1'b0;
    end else if (load_en) begin
      sign_q_reg <= req_a[31] ^ req_b[31];
      sign_r_reg <= req_a[31];
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      pair_reg    <= {32'd0, mag_a};
      divisor_reg <= mag_b;
    end else if (step_en) begin
      // restore on borrow, otherwise keep the difference and set the quotient bit
      if (diff[32]) begin
        pair_reg <= shifted;
      end else begin
        pair_reg <= {diff[31:0], shifted[31:1], 1'b1};
      end
    end
  end

  assign quo_mag  = pair_reg[31:0];
  assign rem_mag  = pair_reg[63:32];
  assign div_zero = (divisor_reg == 32'd0);

  // zero divisor: every step succeeds, all-ones quotient kept without sign fix
  // remainder magnitude is |a|, and the dividend sign turns it back into a
  assign result[31:0]  = (sign_q_reg && !div_zero) ? (~quo_mag + 32'd1) : quo_mag;
  assign result[63:32] = sign_r_reg ? (~rem_mag + 32'd1) : rem_mag;

endmodule

// ------------------------------------------------------------------------
// control
// ------------------------------------------------------------------------

module imuldiv_int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load_en,
  output logic step_en
);

  imuldiv_ctrl_pkg::unit_state_t state;
  imuldiv_ctrl_pkg::count_t      count;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_ctrl_pkg::IDLE;
      count <= '0;
    end else begin
      case (state)
        imuldiv_ctrl_pkg::IDLE: begin
          if (load_en) begin
            state <= imuldiv_ctrl_pkg::CALC;
            count <= '0;
          end
        end
        imuldiv_ctrl_pkg::CALC: begin
          if (count == imuldiv_ctrl_pkg::LAST_ITER) begin
            state <= imuldiv_ctrl_pkg::DONE;
          end else begin
            count <= count + 6'd1;
          end
        end
        default: begin
          if (resp_val && resp_rdy) begin
            state <= imuldiv_ctrl_pkg::IDLE;
          end
        end
      endcase
    end
  end

  // same timing as the multiplier: load on accept, step through calc
  assign req_rdy  = (state == imuldiv_ctrl_pkg::IDLE);
  assign resp_val = (state == imuldiv_ctrl_pkg::DONE);
  assign load_en  = req_rdy && req_val;
  assign step_en  = (state == imuldiv_ctrl_pkg::CALC);

endmodule

// File: rtl/imuldiv_resp_arbiter.sv
// imuldiv response arbiter
// round-robin grant of the multiplier and divider responses onto one port

`timescale 1ns/1ps

module imuldiv_resp_arbiter (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_types_pkg::result_t mul_result,
  input  imuldiv_types_pkg::result_t div_result,
  input  logic                       mul_val,
  input  logic                       div_val,
  output logic                       mul_rdy,
  output logic                       div_rdy,
  output imuldiv_types_pkg::result_t resp_result,
  output imuldiv_types_pkg::fn_t     resp_fn,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  // set: the divider went last, so a tie goes to the multiplier
  logic last_div;
  logic grant_div;

  // a lone requester always wins, a tie goes to the unit not served last
  assign grant_div = (mul_val && div_val) ? !last_div : div_val;

  // a stalled grant must hold, so the bit favours the current winner
  // until its response moves, then flips to the other unit
  always_ff @(posedge clk) begin
    if (reset) begin
      last_div <= 1'b1;
    end else if (resp_val) begin
      last_div <= resp_rdy ? grant_div : !grant_div;
    end
  end

  assign resp_val    = mul_val || div_val;
  assign resp_fn     = grant_div ? imuldiv_ctrl_pkg::FN_DIV : imuldiv_ctrl_pkg::FN_MUL;
  assign resp_result = grant_div ? div_result : mul_result;

  // ready goes back to the winner only
  assign mul_rdy = resp_rdy && !grant_div;
  assign div_rdy = resp_rdy && grant_div;

endmodule

// File: rtl/imuldiv_top.sv
// imuldiv top level
// dispatcher, iterative multiplier and divider, and the shared response arbiter

`timescale 1ns/1ps

module imuldiv_top (
  input  logic                        clk,
  input  logic                        reset,
  input  imuldiv_types_pkg::fn_t      req_fn,
  input  imuldiv_types_pkg::operand_t req_a,
  input  imuldiv_types_pkg::operand_t req_b,
  input  logic                        req_val,
  output logic                        req_rdy,
  output imuldiv_types_pkg::fn_t      resp_fn,
  output imuldiv_types_pkg::result_t  resp_result,
  output logic                        resp_val,
  input  logic                        resp_rdy
);

  imuldiv_types_pkg::result_t mul_resp_result;
  imuldiv_types_pkg::result_t div_resp_result;
  logic                       mul_resp_val;
  logic                       div_resp_val;
  logic                       mul_resp_rdy;
  logic                       div_resp_rdy;

  // one request channel per unit
  imuldiv_req_if mul_req ();
  imuldiv_req_if div_req ();

  imuldiv_req_dispatch i_dispatch (
    .req_fn  (req_fn),
    .req_a   (req_a),
    .req_b   (req_b),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .mul_req (mul_req.dispatch),
    .div_req (div_req.dispatch)
  );

  imuldiv_int_mul_iterative i_mul (
    .clk         (clk),
    .reset       (reset),
    .req         (mul_req.unit),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

  imuldiv_int_div_iterative i_div (
    .clk         (clk),
    .reset       (reset),
    .req         (div_req.unit),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy)
  );

  // both units finish on their own, responses share one port
  imuldiv_resp_arbiter i_arbiter (
    .clk         (clk),
    .reset       (reset),
    .mul_result  (mul_resp_result),
    .div_result  (div_resp_result),
    .mul_val     (mul_resp_val),
    .div_val     (div_resp_val),
    .mul_rdy     (mul_resp_rdy),
    .div_rdy     (div_resp_rdy),
    .resp_result (resp_result),
    .resp_fn     (resp_fn),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

endmodule

// File: test/imuldiv_asserts.sv
// imuldiv checker
// reference results, response timing, grant order and handshake properties

`timescale 1ns/1ps

module imuldiv_asserts (
  input logic                        clk,
  input logic                        reset,
  input imuldiv_types_pkg::fn_t      req_fn,
  input imuldiv_types_pkg::operand_t req_a,
  input imuldiv_types_pkg::operand_t req_b,
  input logic                        req_val,
  input logic                        req_rdy,
  input imuldiv_types_pkg::fn_t      resp_fn,
  input imuldiv_types_pkg::result_t  resp_result,
  input logic                        resp_val,
  input logic                        resp_rdy
);

  // first cycle a unit may show its response after the request transfer
  localparam logic [6:0] RESP_CYCLES = 7'd33;

  int                         fail_count;
  logic                       req_go;
  logic                       resp_go;
  logic                       busy_mul;
  logic                       busy_div;
  logic [6:0]                 age_mul;
  logic [6:0]                 age_div;
  imuldiv_types_pkg::result_t exp_mul;
  imuldiv_types_pkg::result_t exp_div;
  logic                       done_mul;
  logic                       done_div;
  // response stalled on the previous edge
  logic                       held;
  imuldiv_types_pkg::fn_t     held_fn;
  imuldiv_types_pkg::result_t held_result;
  // fn of the last response that transferred
  imuldiv_types_pkg::fn_t     last_fn;
  imuldiv_types_pkg::fn_t     exp_fn;

  initial fail_count = 0;

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------

  function automatic imuldiv_types_pkg::result_t mul_ref(input imuldiv_types_pkg::operand_t a,
                                                         input imuldiv_types_pkg::operand_t b);
    logic signed [63:0] wa;
    logic signed [63:0] wb;
    wa = a;
    wb = b;
    return wa * wb;
  endfunction

  // truncating quotient low, dividend-signed remainder high
  function automatic imuldiv_types_pkg::result_t div_ref(input imuldiv_types_pkg::operand_t a,
                                                         input imuldiv_types_pkg::operand_t b);
    logic signed [63:0] wa;
    logic signed [63:0] wb;
    logic signed [63:0] q;
    logic signed [63:0] r;
    wa = a;
    wb = b;
    if (b == 0) begin
      return {a, 32'hffff_ffff};
    end
    q = wa / wb;
    r = wa % wb;
    return {r[31:0], q[31:0]};
  endfunction

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_mul <= 1'b0;
      busy_div <= 1'b0;
      age_mul  <= '0;
      age_div  <= '0;
      held     <= 1'b0;
      last_fn  <= imuldiv_ctrl_pkg::FN_DIV;
    end else begin
      if (req_go && req_fn == imuldiv_ctrl_pkg::FN_MUL) begin
        busy_mul <= 1'b1;
        age_mul  <= 7'd1;
        exp_mul  <= mul_ref(req_a, req_b);
      end else if (resp_go && resp_fn == imuldiv_ctrl_pkg::FN_MUL) begin
        busy_mul <= 1'b0;
        age_mul  <= '0;
      end else if (busy_mul && age_mul < RESP_CYCLES) begin
        age_mul <= age_mul + 7'd1;
      end
      if (req_go && req_fn == imuldiv_ctrl_pkg::FN_DIV) begin
        busy_div <= 1'b1;
        age_div  <= 7'd1;
        exp_div  <= div_ref(req_a, req_b);
      end else if (resp_go && resp_fn == imuldiv_ctrl_pkg::FN_DIV) begin
        busy_div <= 1'b0;
        age_div  <= '0;
      end else if (busy_div && age_div < RESP_CYCLES) begin
        age_div <= age_div + 7'd1;
      end
      held        <= resp_val && !resp_rdy;
      held_fn     <= resp_fn;
      held_result <= resp_result;
      if (resp_go) begin
        last_fn <= resp_fn;
      end
    end
  end

  assign done_mul = busy_mul && (age_mul == RESP_CYCLES);
  assign done_div = busy_div && (age_div == RESP_CYCLES);

  // stalled grant holds, a tie goes to the unit not served last
  assign exp_fn = held ? held_fn :
                  (done_mul && done_div) ? ~last_fn :
                  (done_div ? imuldiv_ctrl_pkg::FN_DIV : imuldiv_ctrl_pkg::FN_MUL);

  // ------------------------------------------------------------------------
  // properties
  // ------------------------------------------------------------------------

  // resp_val exactly when some unit is 33 or more cycles past its request
  a_resp_timing: assert property (@(posedge clk) disable iff (reset)
    resp_val == (done_mul || done_div))
    else begin
      fail_count++;
      $error("[ERROR] %0t resp_val %0b, mul done %0b, div done %0b",
             $time, resp_val, done_mul, done_div);
    end

  a_grant: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> (resp_fn == exp_fn))
    else begin
      fail_count++;
      $error("[ERROR] %0t resp_fn %0d, expected %0d", $time, resp_fn, exp_fn);
    end

  a_hold: assert property (@(posedge clk) disable iff (reset)
    held |-> (resp_val && resp_fn == held_fn && resp_result == held_result))
    else begin
      fail_count++;
      $error("[ERROR] %0t response changed while resp_rdy was low", $time);
    end

  a_mul_result: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_fn == imuldiv_ctrl_pkg::FN_MUL) |-> (resp_result == exp_mul))
    else begin
      fail_count++;
      $error("[ERROR] %0t mul result %h, expected %h", $time, resp_result, exp_mul);
    end

  a_div_result: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_fn == imuldiv_ctrl_pkg::FN_DIV) |-> (resp_result == exp_div))
    else begin
      fail_count++;
      $error("[ERROR] %0t div result %h, expected %h", $time, resp_result, exp_div);
    end

  // addressed unit is ready exactly when it holds no operation
  a_req_rdy: assert property (@(posedge clk) disable iff (reset)
    req_rdy == !((req_fn == imuldiv_ctrl_pkg::FN_DIV) ? busy_div : busy_mul))
    else begin
      fail_count++;
      $error("[ERROR] %0t req_rdy %0b for fn %0d", $time, req_rdy, req_fn);
    end

endmodule

bind imuldiv_top imuldiv_asserts i_asserts (
  .clk         (clk),
  .reset       (reset),
  .req_fn      (req_fn),
  .req_a       (req_a),
  .req_b       (req_b),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_fn     (resp_fn),
  .resp_result (resp_result),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy)
);

// File: test/imuldiv_tb.sv
// imuldiv testbench
// corner-case, contended and random requests under response back-pressure

`timescale 1ns/1ps

module imuldiv_tb;

  localparam int REQ_TIMEOUT   = 400;
  localparam int DRAIN_TIMEOUT = 400;
  localparam int RANDOM_OPS    = 300;
  localparam imuldiv_types_pkg::operand_t MIN_VAL = 32'h8000_0000;

  logic                        clk;
  logic                        reset;
  imuldiv_types_pkg::fn_t      req_fn;
  imuldiv_types_pkg::operand_t req_a;
  imuldiv_types_pkg::operand_t req_b;
  logic                        req_val;
  logic                        req_rdy;
  imuldiv_types_pkg::fn_t      resp_fn;
  imuldiv_types_pkg::result_t  resp_result;
  logic                        resp_val;
  logic                        resp_rdy;

  // 0 always ready, 1 random stalls, 2 held off
  int rdy_mode;
  int sent_count;
  int done_count;
  int timeout_count;

  imuldiv_top i_dut (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // response back-pressure
  always @(posedge clk) begin
    case (rdy_mode)
      0: resp_rdy <= 1'b1;
      1: resp_rdy <= ($urandom_range(3) != 0);
      default: resp_rdy <= 1'b0;
    endcase
  end

  // count each response on the edge that takes it
  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      done_count++;
    end
  end

  // ------------------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------------------

  task automatic send_req(input imuldiv_types_pkg::fn_t fn,
                          input imuldiv_types_pkg::operand_t a,
                          input imuldiv_types_pkg::operand_t b);
    int waited;
    waited = 0;
    @(posedge clk);
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    @(negedge clk);
    while (!req_rdy && waited < REQ_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (req_rdy) begin
      sent_count++;
    end else begin
      $display("timeout: %s request not accepted within %0d cycles",
               fn ? "div" : "mul", REQ_TIMEOUT);
      timeout_count++;
    end
    // transfer happens on this edge
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (done_count != sent_count && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (done_count != sent_count) begin
      $display("timeout: %0d responses still outstanding after %0d cycles",
               sent_count - done_count, DRAIN_TIMEOUT);
      timeout_count++;
    end
  endtask

  // one operation alone on an always-ready port
  task automatic run_one(input imuldiv_types_pkg::fn_t fn,
                         input imuldiv_types_pkg::operand_t a,
                         input imuldiv_types_pkg::operand_t b);
    send_req(fn, a, b);
    wait_drain();
  endtask

  // mostly plain values, some zero, extreme and minus one
  function automatic imuldiv_types_pkg::operand_t pick_operand();
    logic [31:0] rnd;
    rnd = $urandom;
    case ($urandom_range(7))
      0: return '0;
      1: return MIN_VAL;
      2: return '1;
      3: return 32'h7fff_ffff;
      default: return rnd;
    endcase
  endfunction

  // both units finish behind a held-off port, then share it
  task automatic contend(input imuldiv_types_pkg::fn_t first_fn);
    int waited;
    waited = 0;
    rdy_mode = 2;
    send_req(first_fn, pick_operand(), pick_operand());
    send_req(~first_fn, pick_operand(), pick_operand());
    while (!resp_val && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!resp_val) begin
      $display("timeout: no response during the contention phase");
      timeout_count++;
    end
    // the second unit started a few cycles later
    repeat (6) @(negedge clk);
    rdy_mode = 1;
    wait_drain();
    rdy_mode = 0;
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    logic [31:0] rnd;
    int          i;
    void'($urandom(88527));
    reset         = 1'b1;
    req_fn        = imuldiv_ctrl_pkg::FN_MUL;
    req_a         = '0;
    req_b         = '0;
    req_val       = 1'b0;
    resp_rdy      = 1'b0;
    rdy_mode      = 0;
    sent_count    = 0;
    done_count    = 0;
    timeout_count = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // all sign combinations one at a time for a clean latency
    for (i = 0; i < 4; i++) begin
      run_one(imuldiv_ctrl_pkg::FN_MUL, i[0] ? -32'sd12345 : 32'sd12345,
              i[1] ? -32'sd678 : 32'sd678);
      run_one(imuldiv_ctrl_pkg::FN_DIV, i[0] ? -32'sd100 : 32'sd100,
              i[1] ? -32'sd7 : 32'sd7);
    end

    // most negative value, quotient overflow and divide by zero
    run_one(imuldiv_ctrl_pkg::FN_MUL, MIN_VAL, MIN_VAL);
    run_one(imuldiv_ctrl_pkg::FN_MUL, MIN_VAL, -32'sd1);
    run_one(imuldiv_ctrl_pkg::FN_DIV, MIN_VAL, -32'sd1);
    run_one(imuldiv_ctrl_pkg::FN_DIV, MIN_VAL, 32'sd1);
    run_one(imuldiv_ctrl_pkg::FN_DIV, 32'sd5, 32'sd0);
    run_one(imuldiv_ctrl_pkg::FN_DIV, -32'sd5, 32'sd0);
    run_one(imuldiv_ctrl_pkg::FN_DIV, 32'sd7, -32'sd9);

    for (i = 0; i < 4; i++) begin
      contend(i[0]);
    end

    // random traffic with both units in flight and random stalls
    rdy_mode = 1;
    for (i = 0; i < RANDOM_OPS; i++) begin
      rnd = $urandom;
      send_req(rnd[0], pick_operand(), pick_operand());
    end
    wait_drain();
    rdy_mode = 0;
    repeat (2) @(negedge clk);

    $display("closing: %0d timeouts, %0d assertion failures, %0d of %0d responses",
             timeout_count, i_dut.i_asserts.fail_count, done_count, sent_count);
    if (timeout_count == 0 && i_dut.i_asserts.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: imuldiv.f
rtl/imuldiv_types_pkg.sv
rtl/imuldiv_ctrl_pkg.sv
rtl/imuldiv_req_if.sv
rtl/imuldiv_req_dispatch.sv
rtl/imuldiv_int_mul_iterative.sv
rtl/imuldiv_int_div_iterative.sv
rtl/imuldiv_resp_arbiter.sv
rtl/imuldiv_top.sv
test/imuldiv_asserts.sv
test/imuldiv_tb.sv

// File: run.sh
#!/bin/sh
# builds the imuldiv testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module imuldiv_tb \
  -f imuldiv.f \
  -o imuldiv_sim

# keep running past assertion failures so the closing lines reach the log
./obj_dir/imuldiv_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

grep -q "^Verification passed$" sim.log
